// File: hw/obj_gfx_rom.sv
////////////////////////////////////////
// graphics ROM, 16k words of 4bpp pixels
// request acknowledged after a fixed delay
////////////////////////////////////////
module obj_gfx_rom
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rom_we,
    input  logic [ROM_AW-1:0] rom_waddr,
    input  logic [15:0]       rom_wdata,
    input  logic              rom_cs,
    input  logic [ROM_AW-1:0] rom_addr,
    output logic              rom_ok,
    output logic [15:0]       rom_data
);

    logic [15:0] mem [2**ROM_AW];
    logic        cs_l;       // rom_cs one cycle ago
    logic        ok_r;
    logic [$clog2(ROM_LATENCY+1)-1:0] wait_cnt;

    always_ff @(posedge clk) begin
        if (rom_we) begin
            mem[rom_waddr] <= rom_wdata;
        end
        rom_data <= mem[rom_addr];   // address is held while rom_cs is high
    end

    // latency counter restarts on every rom_cs rise
    always_ff @(posedge clk) begin
        if (rst) begin
            cs_l     <= 1'b0;
            ok_r     <= 1'b0;
            wait_cnt <= '0;
        end else begin
            cs_l <= rom_cs;
            if (!rom_cs) begin
                ok_r     <= 1'b0;
                wait_cnt <= '0;
            end else if (!cs_l) begin
                wait_cnt <= 1'b1;
                ok_r     <= (ROM_LATENCY == 1);
            end else if (!ok_r) begin
                wait_cnt <= wait_cnt + 1'b1;
                ok_r     <= (wait_cnt + 1'b1 == ROM_LATENCY);
            end
        end
    end

    assign rom_ok = ok_r & rom_cs;   // drops with the request

endmodule

// File: hw/obj_line_buffer.sv
////////////////////////////////////////
// double line buffer
// one half is drawn while the other is read out
////////////////////////////////////////
module obj_line_buffer
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               line_sel,
    input  logic               line_we,
    input  logic [LINE_AW-1:0] line_addr,
    input  logic [7:0]         line_din,
    input  logic [7:0]         hdump,
    input  logic               pxl_cen,
    output logic [7:0]         pxl
);

    logic [7:0]       mem [2**(LINE_AW+1)];
    logic             clearing;
    logic [LINE_AW:0] clr_cnt;
    logic [LINE_AW:0] wr_addr;
    logic [LINE_AW:0] rd_addr;

    assign wr_addr = {line_sel, line_addr};
    assign rd_addr = {~line_sel, LINE_AW'(hdump)};

    // sweep both halves to zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            clearing <= 1'b1;
            clr_cnt  <= '0;
        end else if (clearing) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (&clr_cnt) begin
                clearing <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_cnt] <= '0;
        end else if (line_we && line_din[3:0] != 4'd0) begin
            mem[wr_addr] <= line_din;   // pen 0 is see-through
        end
        if (pxl_cen) begin
            pxl          <= mem[rd_addr];
            mem[rd_addr] <= '0;         // erased as read
        end
    end

endmodule

// File: hw/obj_line_render.sv
////////////////////////////////////////
// object line renderer
// walks the table, fetches rows, writes pixels
////////////////////////////////////////
module obj_line_render
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               line_start,
    input  logic [7:0]         vrender,
    input  logic [7:0]         scan_data,
    input  logic               rom_ok,
    input  logic [15:0]        rom_data,
    output logic               done,
    output logic [8:0]         scan_addr,
    output logic               rom_cs,
    output logic [ROM_AW-1:0]  rom_addr,
    output logic               line_we,
    output logic [LINE_AW-1:0] line_addr,
    output logic [7:0]         line_din,
    output logic               line_sel
);

    obj_state_e  st;
    obj_size_e   size;
    logic [8:0]  scan_base;   // byte 0 of the current entry
    logic [7:0]  vline;
    logic [8:0]  pxl_cnt;     // budget count
    logic [9:0]  code;
    logic [3:0]  pal;
    logic [8:0]  xpos;
    logic        hflip;
    logic        vflip;
    logic [4:0]  vsub;        // row inside object, already flipped
    logic [2:0]  word;        // word index in screen order
    logic [1:0]  nib;
    logic [15:0] pix;

    logic [7:0]  size_px;
    logic [4:0]  size_mask;
    logic [2:0]  last_word;
    logic [1:0]  tshift;      // log2 of tiles per side
    logic [7:0]  vdiff;
    logic [2:0]  word_f;
    logic [9:0]  tile;

    always_comb begin
        case (size)
            SIZE_8: begin
                size_px   = 8'd8;
                size_mask = 5'd7;
                last_word = 3'd1;
                tshift    = 2'd0;
            end
            SIZE_16: begin
                size_px   = 8'd16;
                size_mask = 5'd15;
                last_word = 3'd3;
                tshift    = 2'd1;
            end
            default: begin
                size_px   = 8'd32;
                size_mask = 5'd31;
                last_word = 3'd7;
                tshift    = 2'd2;
            end
        endcase
    end

    assign vdiff  = vline - scan_data;   // wraps past 255
    assign word_f = hflip ? (word ^ last_word) : word;

    // tile = code + row * tiles per side + column
    assign tile     = code + (10'(vsub[4:3]) << tshift) + 10'(word_f[2:1]);
    assign rom_addr = {tile, vsub[2:0], word_f[0]};

    // scan_data answers the address set two states earlier
    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= IDLE;
            done      <= 1'b1;
            rom_cs    <= 1'b0;
            line_we   <= 1'b0;
            line_sel  <= 1'b0;
            scan_base <= '0;
            scan_addr <= '0;
            pxl_cnt   <= '0;
            word      <= '0;
            nib       <= '0;
        end else begin
            line_we <= 1'b0;
            if (line_start) begin   // also abandons an unfinished line
                done      <= 1'b0;
                rom_cs    <= 1'b0;
                line_sel  <= ~line_sel;
                vline     <= vrender;
                pxl_cnt   <= '0;
                scan_base <= '0;
                scan_addr <= 9'd4;   // attribute byte first
                st        <= READ_ATTR;
            end else begin
                case (st)
                    READ_ATTR: begin
                        scan_addr <= scan_base + 9'd2;
                        st        <= READ_Y;
                    end
                    READ_Y: begin   // attribute byte arrives
                        xpos[8]   <= scan_data[0];
                        size      <= size_decode(scan_data[2:1]);
                        hflip     <= scan_data[3];
                        vflip     <= scan_data[4];
                        scan_addr <= scan_base;
                        st        <= READ_CODE_LO;
                    end
                    READ_CODE_LO: begin   // Y arrives
                        if (scan_data == 8'(OBJ_END_Y)) begin
                            done <= 1'b1;
                            st   <= IDLE;
                        end else if (vdiff >= size_px) begin
                            st <= NEXT_OBJ;   // not on this line
                        end else begin
                            vsub      <= vdiff[4:0] ^ (vflip ? size_mask : 5'd0);
                            scan_addr <= scan_base + 9'd1;
                            st        <= READ_CODE_HI;
                        end
                    end
                    READ_CODE_HI: begin
                        code[7:0] <= scan_data;
                        scan_addr <= scan_base + 9'd3;
                        st        <= READ_X;
                    end
                    READ_X: begin
                        code[9:8] <= scan_data[1:0];
                        pal       <= scan_data[7:4];
                        st        <= ROM_REQ;
                    end
                    ROM_REQ: begin
                        xpos[7:0] <= scan_data;
                        word      <= '0;
                        rom_cs    <= 1'b1;
                        st        <= ROM_WAIT;
                    end
                    ROM_WAIT: begin
                        if (rom_ok) begin   // waits as long as it takes
                            pix    <= rom_data;
                            rom_cs <= 1'b0;
                            nib    <= '0;
                            st     <= DUMP;
                        end
                    end
                    DUMP: begin   // four pixels, one per cycle
                        line_we   <= 1'b1;
                        line_addr <= xpos;
                        line_din  <= {pal, hflip ? pix[3:0] : pix[15:12]};
                        pix       <= hflip ? (pix >> 4) : (pix << 4);
                        xpos      <= xpos + 9'd1;
                        pxl_cnt   <= pxl_cnt + 9'd1;
                        nib       <= nib + 2'd1;
                        if (nib == 2'd3) begin
                            st <= NEXT_HALF;
                        end
                    end
                    NEXT_HALF: begin
                        if (word == last_word) begin
                            st <= NEXT_OBJ;
                        end else begin
                            word   <= word + 3'd1;
                            rom_cs <= 1'b1;
                            st     <= ROM_WAIT;
                        end
                    end
                    NEXT_OBJ: begin
                        if (scan_base == 9'((OBJ_COUNT-1)*OBJ_BYTES) ||
                            pxl_cnt >= 9'(PXL_BUDGET)) begin
                            done <= 1'b1;
                            st   <= IDLE;
                        end else begin
                            scan_base <= scan_base + 9'(OBJ_BYTES);
                            scan_addr <= scan_base + 9'(OBJ_BYTES + 4);
                            st        <= READ_ATTR;
                        end
                    end
                    default: ;   // idle until the next line
                endcase
            end
        end
    end

endmodule

// File: hw/obj_pkg.sv
////////////////////////////////////////
// object engine shared definitions
// table layout, limits and state encodings
////////////////////////////////////////
package obj_pkg;

    // object attribute table, five bytes per entry
    //   byte 0 : code[7:0]
    //   byte 1 : code[9:8] in bits 1:0, palette in bits 7:4
    //   byte 2 : Y
    //   byte 3 : X[7:0]
    //   byte 4 : X[8] in bit 0, size in 2:1, hflip in 3, vflip in 4
    localparam int OBJ_COUNT   = 64;
    localparam int OBJ_BYTES   = 5;
    localparam int OBJ_END_Y   = 240;   // Y value that ends the list
    localparam int PXL_BUDGET  = 384;   // pixels per line
    localparam int ROM_LATENCY = 3;     // rom_cs rise to rom_ok
    localparam int ROM_AW      = 14;    // tile, row, half
    localparam int LINE_AW     = 9;     // line buffer columns

    typedef enum logic [1:0] {
        SIZE_8  = 2'd0,
        SIZE_16 = 2'd1,
        SIZE_32 = 2'd2
    } obj_size_e;

    typedef enum logic [3:0] {
        IDLE, READ_ATTR, READ_Y, READ_CODE_LO, READ_CODE_HI, READ_X,
        ROM_REQ, ROM_WAIT, DUMP, NEXT_HALF, NEXT_OBJ
    } obj_state_e;

    // size field of byte 4, code 3 draws as 32 pixels
    function automatic obj_size_e size_decode(input logic [1:0] bits);
        case (bits)
            2'd0:    return SIZE_8;
            2'd1:    return SIZE_16;
            default: return SIZE_32;
        endcase
    endfunction

endpackage

// File: hw/obj_table_ram.sv
////////////////////////////////////////
// object attribute table
// CPU write port, registered renderer read port
////////////////////////////////////////
module obj_table_ram
    import obj_pkg::*;
(
    input  logic       clk,
    input  logic       tab_we,
    input  logic [8:0] tab_addr,
    input  logic [7:0] tab_din,
    input  logic [8:0] scan_addr,
    output logic [7:0] scan_data
);

    logic [7:0] mem [OBJ_COUNT*OBJ_BYTES];   // 320 bytes

    // CPU side may update the table while the renderer walks it
    always_ff @(posedge clk) begin
        if (tab_we) begin
            mem[tab_addr] <= tab_din;
        end
    end

    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];   // one cycle read latency
    end

endmodule

// File: hw/obj_video_top.sv
////////////////////////////////////////
// object engine top level
////////////////////////////////////////
module obj_video_top
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // CPU side
    input  logic              tab_we,
    input  logic [8:0]        tab_addr,
    input  logic [7:0]        tab_din,
    input  logic              rom_we,
    input  logic [ROM_AW-1:0] rom_waddr,
    input  logic [15:0]       rom_wdata,
    // video timing
    input  logic              line_start,
    input  logic [7:0]        vrender,
    input  logic [7:0]        hdump,
    input  logic              pxl_cen,
    output logic              done,
    output logic [7:0]        pxl
);

    logic [8:0]         scan_addr;
    logic [7:0]         scan_data;
    logic               rom_cs;
    logic               rom_ok;
    logic [ROM_AW-1:0]  rom_addr;
    logic [15:0]        rom_data;
    logic               line_we;
    logic [LINE_AW-1:0] line_addr;
    logic [7:0]         line_din;
    logic               line_sel;

    obj_table_ram u_table (
        .clk, .tab_we, .tab_addr, .tab_din, .scan_addr, .scan_data
    );

    obj_gfx_rom u_rom (
        .clk, .rst, .rom_we, .rom_waddr, .rom_wdata,
        .rom_cs, .rom_addr, .rom_ok, .rom_data
    );

    obj_line_render u_render (
        .clk, .rst, .line_start, .vrender, .scan_data, .rom_ok, .rom_data,
        .done, .scan_addr, .rom_cs, .rom_addr,
        .line_we, .line_addr, .line_din, .line_sel
    );

    obj_line_buffer u_line (
        .clk, .rst, .line_sel, .line_we, .line_addr, .line_din,
        .hdump, .pxl_cen, .pxl
    );

endmodule

// File: project.f
+incdir+testbench
hw/obj_pkg.sv
hw/obj_table_ram.sv
hw/obj_gfx_rom.sv
hw/obj_line_render.sv
hw/obj_line_buffer.sv
hw/obj_video_top.sv
testbench/obj_tb.sv

// File: run.sh
#!/bin/sh
# build and run the object engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal \
    --top-module obj_tb -f project.f -o obj_sim

# exit status is nonzero when the testbench stops with $fatal
./obj_dir/obj_sim

// File: testbench/obj_model.svh
////////////////////////////////////////
// reference model of the object engine
// table and ROM images, expected line
////////////////////////////////////////

logic [7:0]  tab_img [OBJ_COUNT*OBJ_BYTES];   // mirror of the attribute table
logic [15:0] rom_img [2**ROM_AW];             // mirror of the graphics ROM

// expected 256 visible pixels of one line, palette in 7:4 and pen in 3:0
function automatic logic [255:0][7:0] model_line(input logic [7:0] line);
    logic [255:0][7:0] px;
    logic [7:0]        attr;
    logic [15:0]       data;
    int                base;
    int                y;
    int                size;
    int                vd;
    int                vs;
    int                code;
    int                pal;
    int                xo;
    int                sc;
    int                tile;
    int                pen;
    int                x;
    int                used;
    int                n;
    int                c;
    px   = '0;
    used = 0;
    for (n = 0; n < OBJ_COUNT; n++) begin
        base = n * OBJ_BYTES;
        y    = int'(tab_img[base + 2]);
        if (y == OBJ_END_Y) begin
            break;   // rest of the list is hidden
        end
        attr = tab_img[base + 4];
        size = 8 << ((attr[2:1] == 2'd3) ? 2 : int'(attr[2:1]));
        vd   = (int'(line) - y) & 255;   // rows below the top, wraps past 255
        if (vd < size) begin
            vs   = attr[4] ? size - 1 - vd : vd;
            code = int'({tab_img[base + 1][1:0], tab_img[base]});
            pal  = int'(tab_img[base + 1][7:4]);
            xo   = int'({attr[0], tab_img[base + 3]});
            for (c = 0; c < size; c++) begin
                sc   = attr[3] ? size - 1 - c : c;   // source column
                tile = (code + (vs / 8) * (size / 8) + sc / 8) & 1023;
                data = rom_img[tile * 16 + (vs % 8) * 2 + (sc % 8) / 4];
                pen  = int'(data >> (12 - 4 * (sc % 4))) & 15;
                x    = (xo + c) & 511;
                if (pen != 0 && x < 256) begin
                    px[x] = 8'(pal * 16 + pen);   // later objects win
                end
            end
            used += size;
        end
        // budget is only looked at between objects
        if (used >= PXL_BUDGET) begin
            break;
        end
    end
    return px;
endfunction

// File: testbench/obj_tb.sv
////////////////////////////////////////
// object engine testbench
// renders lines and compares with the model
////////////////////////////////////////
module obj_tb
    import obj_pkg::*;
();

    localparam int LINE_CYCLES    = 2000;
    localparam int RENDERED_LINES = 164;   // sum of count+1 over all line runs
    localparam int SETUP_CYCLES   = 2**ROM_AW + 4*OBJ_COUNT*OBJ_BYTES + 100;

    logic              clk;
    logic              rst;
    logic              tab_we;
    logic [8:0]        tab_addr;
    logic [7:0]        tab_din;
    logic              rom_we;
    logic [ROM_AW-1:0] rom_waddr;
    logic [15:0]       rom_wdata;
    logic              line_start;
    logic [7:0]        vrender;
    logic [7:0]        hdump;
    logic              pxl_cen;
    logic              done;
    logic [7:0]        pxl;

    `include "obj_model.svh"

    obj_video_top obj_video_top_i (
        .clk, .rst, .tab_we, .tab_addr, .tab_din, .rom_we, .rom_waddr, .rom_wdata,
        .line_start, .vrender, .hdump, .pxl_cen, .done, .pxl
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (LINE_CYCLES * RENDERED_LINES + SETUP_CYCLES) @(posedge clk);
        $display("render did not finish before the watchdog ran out");
        $display("*** FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_pixel(input string name, input int col,
                               input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Error %s col %0d: expected %02h, actual %02h", name, col, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected %0b, actual %0b", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "flag mismatch");
        end
    endtask

    // all drivers start and end 5 units after a rising edge
    task automatic write_tab(input int addr, input logic [7:0] data);
        tab_img[addr] = data;
        tab_we        = 1'b1;
        tab_addr      = 9'(addr);
        tab_din       = data;
        @(posedge clk);
        #5;
        tab_we = 1'b0;
    endtask

    task automatic write_rom(input int addr, input logic [15:0] data);
        rom_img[addr] = data;
        rom_we        = 1'b1;
        rom_waddr     = ROM_AW'(addr);
        rom_wdata     = data;
        @(posedge clk);
        #5;
        rom_we = 1'b0;
    endtask

    task automatic set_obj(input int idx, input int code, input int pal, input int y,
                           input int x, input logic [1:0] size, input logic hf,
                           input logic vf);
        int b;
        b = idx * OBJ_BYTES;
        write_tab(b, 8'(code));
        write_tab(b + 1, {4'(pal), 2'b00, 2'(code >> 8)});
        write_tab(b + 2, 8'(y));
        write_tab(b + 3, 8'(x));
        write_tab(b + 4, {3'b000, vf, hf, size, 1'(x >> 8)});
    endtask

    task automatic set_end(input int idx);
        write_tab(idx * OBJ_BYTES + 2, 8'(OBJ_END_Y));
    endtask

    task automatic start_line(input logic [7:0] line);
        line_start = 1'b1;
        vrender    = line;
        @(posedge clk);
        #5;
        line_start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done) begin
            @(posedge clk);
            #5;
            n++;
            if (n > LINE_CYCLES) begin
                $display("render did not finish within %0d cycles", LINE_CYCLES);
                $display("*** FAILED ***");
                $fatal(1, "render timeout");
            end
        end
    endtask

    task automatic read_line(input string name, input logic [255:0][7:0] exp_px);
        int h;
        hdump   = 8'd0;
        pxl_cen = 1'b1;
        for (h = 1; h <= 256; h++) begin
            @(posedge clk);
            #5;
            check_pixel(name, h - 1, exp_px[h - 1], pxl);   // one cycle behind hdump
            if (h < 256) begin
                hdump = 8'(h);
            end else begin
                pxl_cen = 1'b0;
            end
        end
    endtask

    // renders count lines from first and reads each back during the next render
    task automatic check_lines(input string name, input int first, input int count);
        logic [255:0][7:0] exp_px;
        int                k;
        start_line(8'(first));
        wait_done();
        for (k = 1; k <= count; k++) begin
            exp_px = model_line(8'(first + k - 1));
            if (k == count) begin
                set_end(0);   // last render draws nothing so both halves end up clean
            end
            start_line(8'(first + k));
            read_line($sformatf("%s line %0d", name, (first + k - 1) % 256), exp_px);
            wait_done();
        end
    endtask

    initial begin
        int i;
        rst        = 1'b1;
        tab_we     = 1'b0;
        tab_addr   = '0;
        tab_din    = '0;
        rom_we     = 1'b0;
        rom_waddr  = '0;
        rom_wdata  = '0;
        line_start = 1'b0;
        vrender    = '0;
        hdump      = '0;
        pxl_cen    = 1'b0;
        void'($urandom(9));
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        check_flag("reset_done", 1'b1, done);

        // random graphics load outlasts the buffer clear sweep
        for (i = 0; i < 2**ROM_AW; i++) begin
            write_rom(i, 16'($urandom));
        end

        set_obj(0, 5, 3, 50, 20, SIZE_8, 1'b0, 1'b0);
        set_end(1);
        check_lines("single_8x8", 48, 12);

        set_obj(0, 16, 5, 100, 40, SIZE_16, 1'b0, 1'b0);
        set_obj(1, 64, 7, 250, 230, SIZE_32, 1'b0, 1'b0);   // wraps past 255 and runs off the right edge
        set_end(2);
        check_lines("size_16", 98, 20);
        set_obj(0, 16, 5, 100, 40, SIZE_16, 1'b0, 1'b0);
        check_lines("size_32_wrap", 246, 36);

        for (i = 0; i < 4; i++) begin
            set_obj(i, 40, 8 + i, 60, i * 40, SIZE_16, 1'(i % 2), 1'(i / 2));
        end
        set_end(4);
        check_lines("flip", 60, 16);

        // tile 900 has pen 0 holes
        for (i = 0; i < 8; i++) begin
            write_rom(900 * 16 + i * 2, 16'h1002 + 16'(i));
            write_rom(900 * 16 + i * 2 + 1, 16'h0a0b);
        end
        set_obj(0, 20, 2, 150, 30, SIZE_16, 1'b0, 1'b0);
        set_obj(1, 900, 9, 152, 34, SIZE_8, 1'b0, 1'b0);
        set_end(2);
        check_lines("overlap", 148, 20);

        set_obj(0, 100, 4, 70, 10, SIZE_8, 1'b0, 1'b0);
        set_obj(2, 101, 6, 70, 12, SIZE_8, 1'b0, 1'b0);
        set_end(1);
        check_lines("terminator", 68, 8);

        for (i = 0; i < 24; i++) begin
            set_obj(i, 200 + i * 4, i % 16, 10, (i * 37) % 250, 2'(i % 3),
                    1'((i / 3) % 2), 1'b0);
        end
        set_end(24);
        check_lines("budget", 12, 4);

        for (i = 0; i < OBJ_COUNT; i++) begin
            set_obj(i, $urandom % 1024, $urandom % 16, $urandom % 240, $urandom % 300,
                    2'($urandom), 1'($urandom), 1'($urandom));
        end
        check_lines("random", int'($urandom % 256), 40);

        $display("*** PASSED ***");
        $finish;
    end

endmodule
